// ==== logic/issue_pkg.sv ====
package issue_pkg;

    // ----------------------------------------------------------
    // widths
    // ----------------------------------------------------------
    localparam int unsigned XLEN       = 32;
    localparam int unsigned REG_ADDR_W = 5;
    localparam int unsigned TRANS_ID_W = 3;

    // data word, register address and scoreboard tag
    typedef logic [XLEN-1:0]       xlen_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TRANS_ID_W-1:0] trans_id_t;
    // operation code, passed through to the units untouched
    typedef logic [6:0]            fu_op_t;

    // functional unit that executes an entry, NONE needs no unit
    typedef enum logic [2:0] {
        NONE,
        ALU,
        CTRL_FLOW,
        MULT,
        LOAD,
        STORE,
        CSR
    } fu_t;

    // pending writer per architectural register
    typedef fu_t [2**REG_ADDR_W-1:0] clobber_t;

    // ----------------------------------------------------------
    // structs between scoreboard, stage and units
    // ----------------------------------------------------------
    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        xlen_t     imm;
        xlen_t     pc;
        trans_id_t trans_id;
        logic      use_imm;
        logic      use_pc;
        logic      use_zimm;
        // exception raised by an earlier stage
        logic      ex_valid;
    } issue_entry_t;

    // one forward answer from the scoreboard
    typedef struct packed {
        xlen_t value;
        logic  valid;
    } fwd_t;

    // one register write from commit
    typedef struct packed {
        reg_addr_t waddr;
        xlen_t     wdata;
        logic      we;
    } commit_port_t;

    typedef struct packed {
        fu_t       fu;
        fu_op_t    op;
        xlen_t     operand_a;
        xlen_t     operand_b;
        xlen_t     imm;
        trans_id_t trans_id;
    } fu_data_t;

    // one strobe per unit, loads and stores share the lsu strobe
    typedef struct packed {
        logic alu;
        logic branch;
        logic lsu;
        logic mult;
        logic csr;
    } fu_valid_t;

endpackage

// ==== logic/int_regfile.sv ====
module int_regfile #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    // two combinational read ports, rs1 at index 0 and rs2 at index 1
    input  issue_pkg::reg_addr_t [1:0]                    raddr_i,
    output issue_pkg::xlen_t [1:0]                        rdata_o,
    // one write port per commit port
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i
);

    // x1..x31 only, x0 has no storage
    issue_pkg::xlen_t [31:1] regs_q;

    // ----------------------------------------------------------
    // write side
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            regs_q <= '0;
        end else begin
            // later ports overwrite earlier ones on the same address
            for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
                if (commit_i[i].we && (commit_i[i].waddr != '0)) begin
                    regs_q[commit_i[i].waddr] <= commit_i[i].wdata;
                end
            end
        end
    end

    // ----------------------------------------------------------
    // read side
    // ----------------------------------------------------------
    // no bypass, a write at edge n shows up from cycle n+1
    always_comb begin : read_ports
        for (int unsigned r = 0; r < 2; r++) begin
            if (raddr_i[r] == '0) begin
                // x0 is hard-wired
                rdata_o[r] = '0;
            end else begin
                rdata_o[r] = regs_q[raddr_i[r]];
            end
        end
    end

endmodule

// ==== logic/hazard_check.sv ====
module hazard_check #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  issue_pkg::issue_entry_t                       entry_i,
    input  logic                                          issue_valid_i,
    input  issue_pkg::clobber_t                           rd_clobber_i,
    input  issue_pkg::fwd_t                               fwd1_i,
    input  issue_pkg::fwd_t                               fwd2_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    input  logic                                          flu_ready_i,
    input  logic                                          lsu_ready_i,
    // registered mult strobe of the execute register
    input  logic                                          mult_issued_i,
    output logic                                          issue_ack_o,
    // bit 0 forwards rs1, bit 1 forwards rs2
    output logic [1:0]                                    fwd_sel_o
);

    // result per source is {stall, forward}
    logic [1:0] rs1_res;
    logic [1:0] rs2_res;
    logic       stall;
    logic       fu_busy;
    logic       rd_free;
    logic       rd_released;

    // a clobbered source is forwarded only if the answer is valid
    // and the writer is not the csr unit, csr results come from the regfile
    function automatic logic [1:0] check_src(issue_pkg::fu_t owner, logic fwd_valid);
        logic [1:0] res;
        res = 2'b00;
        if (owner != issue_pkg::NONE) begin
            if (fwd_valid && (owner != issue_pkg::CSR)) begin
                res = 2'b01;
            end else begin
                res = 2'b10;
            end
        end
        return res;
    endfunction

    // ----------------------------------------------------------
    // source operands
    // ----------------------------------------------------------
    always_comb begin : src_check
        // zimm turns the rs1 field into an immediate, nothing to wait on
        if (entry_i.use_zimm) begin
            rs1_res = 2'b00;
        end else begin
            rs1_res = check_src(rd_clobber_i[entry_i.rs1], fwd1_i.valid);
        end
        rs2_res = check_src(rd_clobber_i[entry_i.rs2], fwd2_i.valid);
    end

    assign stall     = rs1_res[1] | rs2_res[1];
    assign fwd_sel_o = {rs2_res[0], rs1_res[0]};

    // busy signal of the unit the entry needs
    always_comb begin : unit_busy
        unique case (entry_i.fu)
            issue_pkg::ALU, issue_pkg::CTRL_FLOW,
            issue_pkg::CSR, issue_pkg::MULT:   fu_busy = ~flu_ready_i;
            issue_pkg::LOAD, issue_pkg::STORE: fu_busy = ~lsu_ready_i;
            default:                           fu_busy = 1'b0;
        endcase
    end

    // ----------------------------------------------------------
    // write-after-write
    // ----------------------------------------------------------
    assign rd_free = (rd_clobber_i[entry_i.rd] == issue_pkg::NONE);

    // commit writing rd this very cycle frees it
    always_comb begin : waw_release
        rd_released = 1'b0;
        for (int unsigned i = 0; i < NR_COMMIT_PORTS; i++) begin
            if (commit_i[i].we && (commit_i[i].waddr == entry_i.rd)) begin
                rd_released = 1'b1;
            end
        end
    end

    always_comb begin : issue_ack
        issue_ack_o = 1'b0;
        if (issue_valid_i) begin
            if (!stall && !fu_busy && (rd_free || rd_released)) begin
                issue_ack_o = 1'b1;
            end
            // exceptions and unit-less entries pass without a unit
            if (entry_i.ex_valid || (entry_i.fu == issue_pkg::NONE)) begin
                issue_ack_o = 1'b1;
            end
        end
        // only a multiply may follow a multiply on the shared result bus
        if (mult_issued_i && (entry_i.fu != issue_pkg::MULT)) begin
            issue_ack_o = 1'b0;
        end
    end

endmodule

// ==== logic/ex_issue_reg.sv ====
module ex_issue_reg (
    input  logic                    clk_i,
    input  logic                    rst_n_i,
    input  logic                    flush_i,
    input  issue_pkg::issue_entry_t entry_i,
    // acknowledge and valid together
    input  logic                    issue_fire_i,
    input  logic [1:0]              fwd_sel_i,
    input  issue_pkg::fwd_t         fwd1_i,
    input  issue_pkg::fwd_t         fwd2_i,
    input  issue_pkg::xlen_t [1:0]  rf_rdata_i,
    output issue_pkg::fu_data_t     fu_data_o,
    output issue_pkg::fu_valid_t    fu_valid_o
);

    issue_pkg::fu_data_t  data_d;
    issue_pkg::fu_data_t  data_q;
    issue_pkg::fu_valid_t valid_d;
    issue_pkg::fu_valid_t valid_q;

    // ----------------------------------------------------------
    // operand select
    // ----------------------------------------------------------
    always_comb begin : operand_select
        data_d.fu       = entry_i.fu;
        data_d.op       = entry_i.op;
        data_d.trans_id = entry_i.trans_id;
        // stores and branches carry their immediate here
        data_d.imm      = entry_i.imm;

        // regfile by default, forward answer overrides
        data_d.operand_a = fwd_sel_i[0] ? fwd1_i.value : rf_rdata_i[0];
        data_d.operand_b = fwd_sel_i[1] ? fwd2_i.value : rf_rdata_i[1];

        // pc already spans a full word, no extension left to do
        if (entry_i.use_pc) begin
            data_d.operand_a = entry_i.pc;
        end
        // zimm wins over pc
        if (entry_i.use_zimm) begin
            data_d.operand_a = {{(issue_pkg::XLEN-issue_pkg::REG_ADDR_W){1'b0}}, entry_i.rs1};
        end
        // store and branch keep rs2 in operand b
        if (entry_i.use_imm && (entry_i.fu != issue_pkg::STORE)
                && (entry_i.fu != issue_pkg::CTRL_FLOW)) begin
            data_d.operand_b = entry_i.imm;
        end
    end

    // ----------------------------------------------------------
    // unit strobes
    // ----------------------------------------------------------
    always_comb begin : strobe_select
        valid_d = '0;
        if (issue_fire_i && !flush_i && !entry_i.ex_valid) begin
            unique case (entry_i.fu)
                issue_pkg::ALU:                    valid_d.alu    = 1'b1;
                issue_pkg::CTRL_FLOW:              valid_d.branch = 1'b1;
                issue_pkg::MULT:                   valid_d.mult   = 1'b1;
                issue_pkg::LOAD, issue_pkg::STORE: valid_d.lsu    = 1'b1;
                issue_pkg::CSR:                    valid_d.csr    = 1'b1;
                // NONE raises nothing
                default:                           valid_d        = '0;
            endcase
        end
    end

    // data loads every cycle, the strobe qualifies it
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            data_q  <= '0;
            valid_q <= '0;
        end else begin
            data_q  <= data_d;
            valid_q <= valid_d;
        end
    end

    assign fu_data_o  = data_q;
    assign fu_valid_o = valid_q;

endmodule

// ==== logic/issue_stage.sv ====
module issue_stage #(
    parameter int unsigned NR_COMMIT_PORTS = 2
) (
    input  logic                                          clk_i,
    input  logic                                          rst_n_i,
    input  logic                                          flush_i,
    // scoreboard handshake
    input  issue_pkg::issue_entry_t                       issue_instr_i,
    input  logic                                          issue_valid_i,
    output logic                                          issue_ack_o,
    // forward lookup
    output issue_pkg::reg_addr_t                          rs1_o,
    output issue_pkg::reg_addr_t                          rs2_o,
    input  issue_pkg::fwd_t                               fwd1_i,
    input  issue_pkg::fwd_t                               fwd2_i,
    input  issue_pkg::clobber_t                           rd_clobber_i,
    input  issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i,
    // execute units
    input  logic                                          flu_ready_i,
    input  logic                                          lsu_ready_i,
    output issue_pkg::fu_data_t                           fu_data_o,
    output issue_pkg::fu_valid_t                          fu_valid_o
);

    issue_pkg::xlen_t [1:0] rf_rdata;
    logic [1:0]             fwd_sel;
    logic                   issue_fire;

    // scoreboard answers the forward lookup in the same cycle
    assign rs1_o      = issue_instr_i.rs1;
    assign rs2_o      = issue_instr_i.rs2;
    assign issue_fire = issue_ack_o & issue_valid_i;

    int_regfile #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) u_int_regfile (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .raddr_i ({issue_instr_i.rs2, issue_instr_i.rs1}),
        .rdata_o (rf_rdata),
        .commit_i(commit_i)
    );

    // mult strobe of the execute register closes the multiply loop
    hazard_check #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) u_hazard_check (
        .entry_i      (issue_instr_i),
        .issue_valid_i(issue_valid_i),
        .rd_clobber_i (rd_clobber_i),
        .fwd1_i       (fwd1_i),
        .fwd2_i       (fwd2_i),
        .commit_i     (commit_i),
        .flu_ready_i  (flu_ready_i),
        .lsu_ready_i  (lsu_ready_i),
        .mult_issued_i(fu_valid_o.mult),
        .issue_ack_o  (issue_ack_o),
        .fwd_sel_o    (fwd_sel)
    );

    ex_issue_reg u_ex_issue_reg (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .entry_i     (issue_instr_i),
        .issue_fire_i(issue_fire),
        .fwd_sel_i   (fwd_sel),
        .fwd1_i      (fwd1_i),
        .fwd2_i      (fwd2_i),
        .rf_rdata_i  (rf_rdata),
        .fu_data_o   (fu_data_o),
        .fu_valid_o  (fu_valid_o)
    );

endmodule

// ==== test/issue_stage_asserts.sv ====
module issue_stage_asserts (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 flush_i,
    input logic                 issue_valid_i,
    input logic                 issue_ack_o,
    input issue_pkg::fu_valid_t fu_valid_o
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------
    // strobe properties
    // ----------------------------------------------------------
    // at most one unit gets the entry
    one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(fu_valid_o))
        else $error("more than one unit strobe high");

    // flushed entry never reaches a unit
    flush_kills_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (flush_i && issue_valid_i && issue_ack_o) |=> (fu_valid_o == '0))
        else $error("unit strobe raised after a flush in the accept cycle");

    // synchronous reset clears the strobes at the next edge
    quiet_in_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> (fu_valid_o == '0))
        else $error("unit strobe high during reset");

endmodule

bind issue_stage issue_stage_asserts u_asserts (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .flush_i      (flush_i),
    .issue_valid_i(issue_valid_i),
    .issue_ack_o  (issue_ack_o),
    .fu_valid_o   (fu_valid_o)
);

// ==== test/issue_stage_tb.sv ====
module issue_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD      = 100;
    localparam int RESET_CYCLES    = 3;
    localparam int NR_COMMIT_PORTS = 2;

    // one table row, applied for one cycle
    typedef struct packed {
        issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit;
        issue_pkg::fu_t          clob_rs1;
        issue_pkg::fu_t          clob_rs2;
        issue_pkg::fu_t          clob_rd;
        issue_pkg::fwd_t         fwd1;
        issue_pkg::fwd_t         fwd2;
        logic                    flu_ready;
        logic                    lsu_ready;
        logic                    flush;
        issue_pkg::issue_entry_t entry;
        // expected acknowledge in the same cycle
        logic                    exp_ack;
        // expected execute register one cycle later
        issue_pkg::xlen_t        exp_a;
        issue_pkg::xlen_t        exp_b;
        issue_pkg::xlen_t        exp_imm;
        issue_pkg::fu_valid_t    exp_valid;
    } row_t;

    logic                                          clk_i;
    logic                                          rst_n_i;
    logic                                          flush_i;
    issue_pkg::issue_entry_t                       issue_instr_i;
    logic                                          issue_valid_i;
    logic                                          issue_ack_o;
    issue_pkg::reg_addr_t                          rs1_o;
    issue_pkg::reg_addr_t                          rs2_o;
    issue_pkg::fwd_t                               fwd1_i;
    issue_pkg::fwd_t                               fwd2_i;
    issue_pkg::clobber_t                           rd_clobber_i;
    issue_pkg::commit_port_t [NR_COMMIT_PORTS-1:0] commit_i;
    logic                                          flu_ready_i;
    logic                                          lsu_ready_i;
    issue_pkg::fu_data_t                           fu_data_o;
    issue_pkg::fu_valid_t                          fu_valid_o;

    row_t             rows[$];
    string            names[$];
    // register values the stage should read back
    issue_pkg::xlen_t shadow[32];
    integer           seed;
    int               cycles;
    int               cycle_limit;

    issue_stage #(
        .NR_COMMIT_PORTS(NR_COMMIT_PORTS)
    ) dut (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .issue_instr_i(issue_instr_i),
        .issue_valid_i(issue_valid_i),
        .issue_ack_o  (issue_ack_o),
        .rs1_o        (rs1_o),
        .rs2_o        (rs2_o),
        .fwd1_i       (fwd1_i),
        .fwd2_i       (fwd2_i),
        .rd_clobber_i (rd_clobber_i),
        .commit_i     (commit_i),
        .flu_ready_i  (flu_ready_i),
        .lsu_ready_i  (lsu_ready_i),
        .fu_data_o    (fu_data_o),
        .fu_valid_o   (fu_valid_o)
    );

    always #(CLK_PERIOD/2) clk_i = ~clk_i;

    // ----------------------------------------------------------
    // run limit
    // ----------------------------------------------------------
    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic compare(string name, string what, logic [31:0] exp, logic [31:0] act);
        if (act !== exp) begin
            $display("mismatch: row %s %s expected %h actual %h", name, what, exp, act);
            $display("TEST FAILED");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    // strobe of the unit that executes fu, lsu shared by load and store
    function automatic issue_pkg::fu_valid_t unit_strobe(issue_pkg::fu_t fu);
        issue_pkg::fu_valid_t v;
        v = '0;
        case (fu)
            issue_pkg::ALU:                    v.alu    = 1'b1;
            issue_pkg::CTRL_FLOW:              v.branch = 1'b1;
            issue_pkg::MULT:                   v.mult   = 1'b1;
            issue_pkg::LOAD, issue_pkg::STORE: v.lsu    = 1'b1;
            issue_pkg::CSR:                    v.csr    = 1'b1;
            default:                           v        = '0;
        endcase
        return v;
    endfunction

    function automatic issue_pkg::commit_port_t write_port(issue_pkg::reg_addr_t a,
                                                           issue_pkg::xlen_t d);
        return '{waddr: a, wdata: d, we: 1'b1};
    endfunction

    // accepted row with operands from the register file, all units ready
    function automatic row_t new_row(issue_pkg::fu_t fu, issue_pkg::reg_addr_t rs1,
                                     issue_pkg::reg_addr_t rs2, issue_pkg::reg_addr_t rd);
        row_t r;
        r                = '0;
        r.entry.fu       = fu;
        r.entry.rs1      = rs1;
        r.entry.rs2      = rs2;
        r.entry.rd       = rd;
        r.entry.imm      = $random(seed);
        r.entry.pc       = 32'h8000_1000 + 32'(rows.size() * 4);
        r.entry.op       = 7'(rows.size());
        r.entry.trans_id = 3'(rows.size());
        r.flu_ready      = 1'b1;
        r.lsu_ready      = 1'b1;
        r.exp_ack        = 1'b1;
        r.exp_a          = shadow[rs1];
        r.exp_b          = shadow[rs2];
        r.exp_imm        = r.entry.imm;
        r.exp_valid      = unit_strobe(fu);
        return r;
    endfunction

    function automatic row_t refuse(row_t r);
        r.exp_ack   = 1'b0;
        r.exp_valid = '0;
        return r;
    endfunction

    // commits land at the edge, so later rows see the new value
    task automatic add_row(string name, row_t r);
        rows.push_back(r);
        names.push_back(name);
        for (int p = 0; p < NR_COMMIT_PORTS; p++) begin
            if (r.commit[p].we && (r.commit[p].waddr != '0)) begin
                shadow[r.commit[p].waddr] = r.commit[p].wdata;
            end
        end
    endtask

    // ----------------------------------------------------------
    // stimulus table
    // ----------------------------------------------------------
    task automatic build_table();
        row_t             r;
        issue_pkg::xlen_t wa;
        issue_pkg::xlen_t wb;
        issue_pkg::xlen_t wc;
        issue_pkg::xlen_t wd;
        issue_pkg::xlen_t wf;
        foreach (shadow[i]) shadow[i] = '0;
        wa = $random(seed);
        wb = $random(seed);
        wc = $random(seed);
        wd = $random(seed);
        wf = $random(seed);

        // register file writes and reads, x0 stays zero
        r = new_row(issue_pkg::NONE, 5'd0, 5'd0, 5'd0);
        r.commit[0] = write_port(5'd5, wa);
        add_row("commit_x5", r);
        r = new_row(issue_pkg::NONE, 5'd0, 5'd0, 5'd0);
        r.commit[0] = write_port(5'd0, wb);
        r.commit[1] = write_port(5'd6, wc);
        add_row("commit_x0_x6", r);
        add_row("rf_read", new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd1));
        add_row("read_x0", new_row(issue_pkg::ALU, 5'd0, 5'd5, 5'd1));

        // forwarding and csr results
        r = new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd2);
        r.clob_rs1 = issue_pkg::ALU;
        r.fwd1     = '{value: wd, valid: 1'b1};
        r.exp_a    = wd;
        add_row("fwd_rs1", r);
        r = new_row(issue_pkg::LOAD, 5'd6, 5'd5, 5'd2);
        r.clob_rs2 = issue_pkg::LOAD;
        r.fwd2     = '{value: wb, valid: 1'b1};
        r.exp_b    = wb;
        add_row("fwd_rs2", r);
        r = refuse(new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd2));
        r.clob_rs1 = issue_pkg::ALU;
        r.fwd1     = '{value: wd, valid: 1'b0};
        add_row("fwd_not_valid", r);
        r = refuse(new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd2));
        r.clob_rs2 = issue_pkg::CSR;
        r.fwd2     = '{value: wd, valid: 1'b1};
        add_row("csr_no_fwd", r);

        // write-after-write on rd, released by a commit to rd
        r = refuse(new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd3));
        r.clob_rd = issue_pkg::MULT;
        add_row("waw_block", r);
        r = new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd3);
        r.clob_rd   = issue_pkg::MULT;
        r.commit[1] = write_port(5'd3, wf);
        add_row("waw_release", r);

        // busy units and the multiply rule
        r = refuse(new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd1));
        r.flu_ready = 1'b0;
        add_row("flu_busy_alu", r);
        r = refuse(new_row(issue_pkg::MULT, 5'd5, 5'd6, 5'd1));
        r.flu_ready = 1'b0;
        add_row("flu_busy_mult", r);
        r = refuse(new_row(issue_pkg::LOAD, 5'd5, 5'd6, 5'd1));
        r.lsu_ready = 1'b0;
        add_row("lsu_busy_load", r);
        add_row("mult_first", new_row(issue_pkg::MULT, 5'd3, 5'd5, 5'd1));
        add_row("mult_after_mult", new_row(issue_pkg::MULT, 5'd5, 5'd3, 5'd1));
        add_row("alu_after_mult", refuse(new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd1)));
        add_row("alu_released", new_row(issue_pkg::ALU, 5'd6, 5'd5, 5'd1));

        // operand sources
        r = new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd1);
        r.entry.use_pc  = 1'b1;
        r.entry.use_imm = 1'b1;
        r.exp_a         = r.entry.pc;
        r.exp_b         = r.entry.imm;
        add_row("pc_and_imm", r);
        // zimm ignores the clobbered rs1 field
        r = new_row(issue_pkg::CSR, 5'd21, 5'd6, 5'd4);
        r.entry.use_zimm = 1'b1;
        r.clob_rs1       = issue_pkg::ALU;
        r.exp_a          = 32'd21;
        add_row("zimm", r);
        r = new_row(issue_pkg::STORE, 5'd5, 5'd6, 5'd0);
        r.entry.use_imm = 1'b1;
        add_row("store_imm", r);
        r = new_row(issue_pkg::CTRL_FLOW, 5'd5, 5'd6, 5'd0);
        r.entry.use_imm = 1'b1;
        add_row("branch_imm", r);

        // unit-less entries, flush
        r = new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd1);
        r.entry.ex_valid = 1'b1;
        r.flu_ready      = 1'b0;
        r.exp_valid      = '0;
        add_row("exception_busy", r);
        r = new_row(issue_pkg::NONE, 5'd5, 5'd6, 5'd1);
        r.flu_ready = 1'b0;
        r.lsu_ready = 1'b0;
        add_row("none_busy", r);
        r = new_row(issue_pkg::ALU, 5'd5, 5'd6, 5'd1);
        r.flush     = 1'b1;
        r.exp_valid = '0;
        add_row("flush", r);
        add_row("after_flush", new_row(issue_pkg::ALU, 5'd3, 5'd6, 5'd1));
    endtask

    task automatic apply_row(row_t r);
        commit_i     = r.commit;
        rd_clobber_i = '0;
        if (r.clob_rs1 != issue_pkg::NONE) rd_clobber_i[r.entry.rs1] = r.clob_rs1;
        if (r.clob_rs2 != issue_pkg::NONE) rd_clobber_i[r.entry.rs2] = r.clob_rs2;
        if (r.clob_rd != issue_pkg::NONE) rd_clobber_i[r.entry.rd] = r.clob_rd;
        fwd1_i        = r.fwd1;
        fwd2_i        = r.fwd2;
        flu_ready_i   = r.flu_ready;
        lsu_ready_i   = r.lsu_ready;
        flush_i       = r.flush;
        issue_instr_i = r.entry;
        issue_valid_i = 1'b1;
    endtask

    // data is only meaningful behind a strobe
    task automatic check_outputs(int i);
        row_t r;
        r = rows[i];
        compare(names[i], "fu_valid", 32'(r.exp_valid), 32'(fu_valid_o));
        if (r.exp_valid != '0) begin
            compare(names[i], "fu", 32'(r.entry.fu), 32'(fu_data_o.fu));
            compare(names[i], "op", 32'(r.entry.op), 32'(fu_data_o.op));
            compare(names[i], "trans_id", 32'(r.entry.trans_id), 32'(fu_data_o.trans_id));
            compare(names[i], "operand_a", r.exp_a, fu_data_o.operand_a);
            compare(names[i], "operand_b", r.exp_b, fu_data_o.operand_b);
            compare(names[i], "imm", r.exp_imm, fu_data_o.imm);
        end
    endtask

    // ----------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------
    initial begin
        clk_i         = 1'b0;
        rst_n_i       = 1'b0;
        flush_i       = 1'b0;
        issue_instr_i = '0;
        issue_valid_i = 1'b0;
        fwd1_i        = '0;
        fwd2_i        = '0;
        rd_clobber_i  = '0;
        commit_i      = '0;
        flu_ready_i   = 1'b0;
        lsu_ready_i   = 1'b0;
        seed          = 32'hce6a_6e80;
        cycles        = 0;
        build_table();
        cycle_limit = 4 * rows.size() + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;

        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            // acknowledge is combinational, sample it mid low phase
            #(CLK_PERIOD/4);
            compare(names[i], "issue_ack", 32'(rows[i].exp_ack), 32'(issue_ack_o));
            // forward lookup addresses come straight from the entry
            compare(names[i], "rs1_o", 32'(rows[i].entry.rs1), 32'(rs1_o));
            compare(names[i], "rs2_o", 32'(rows[i].entry.rs2), 32'(rs2_o));
            @(posedge clk_i);
            @(negedge clk_i);
            check_outputs(i);
        end

        $display("TEST OK");
        $finish;
    end

endmodule

// ==== sim.f ====
logic/issue_pkg.sv
logic/int_regfile.sv
logic/hazard_check.sv
logic/ex_issue_reg.sv
logic/issue_stage.sv
test/issue_stage_asserts.sv
test/issue_stage_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = issue_stage_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
